// ==== sources.f ====
rv32i_types.sv
queue.sv
fetch_unit.sv
decode_unit.sv
frontend_top.sv
frontend_tb.sv

// ==== frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb;

    localparam int total_outputs = 600;
    localparam int timeout_cycles = 4000;   // well above the expected run length
    localparam int max_outstanding = rv32i_types::fetch_queue_depth + 2;

    logic                  clk;
    logic                  rst;
    logic [31:0]           imem_rdata;
    logic                  dec_ready;
    logic                  imem_req;
    logic [31:0]           imem_addr;
    logic                  dec_valid;
    rv32i_types::decoded_t dec_data;

    logic [31:0] imem [256];        // instruction memory model
    logic [31:0] pc_queue [$];      // pcs requested but not yet accepted
    integer      seed;
    int          cycle_count;
    int          accepted;
    int          low_run;           // consecutive cycles with dec_ready low
    int          high_run;
    int          gap;               // cycles since the last accepted output
    logic [31:0] next_req_addr;
    logic        resp_pending;      // memory answers in the next cycle
    logic [31:0] resp_addr;
    logic        prev_stall;
    rv32i_types::decoded_t prev_data;

    frontend_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_rdata (imem_rdata),
        .dec_ready  (dec_ready),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .dec_valid  (dec_valid),
        .dec_data   (dec_data)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] want);
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        $display("Test failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Test failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        assert (got === want) else report_mismatch(name, got, want);
    endtask

    function automatic logic [6:0] legal_opcode(input int idx);
        case (idx)
            0: return rv32i_types::op_lui;
            1: return rv32i_types::op_auipc;
            2: return rv32i_types::op_jal;
            3: return rv32i_types::op_jalr;
            4: return rv32i_types::op_branch;
            5: return rv32i_types::op_load;
            6: return rv32i_types::op_store;
            7: return rv32i_types::op_imm;
            default: return rv32i_types::op_reg;
        endcase
    endfunction

    // expected decode of one memory word, built format by format
    function automatic rv32i_types::decoded_t ref_decode(input logic [31:0] pc,
                                                         input logic [31:0] w);
        rv32i_types::decoded_t d;
        logic [31:0] sx;
        logic        legal;
        int          i;
        legal = 1'b0;
        for (i = 0; i < 9; i++) begin
            if (w[6:0] == legal_opcode(i)) legal = 1'b1;
        end
        sx = {32{w[31]}};   // sign fill
        d.pc = pc;
        d.rd = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.funct3 = w[14:12];
        d.funct7 = w[31:25];
        d.op = legal ? rv32i_types::opcode_e'(w[6:0]) : rv32i_types::op_illegal;
        d.illegal = !legal;
        case (d.op)
            rv32i_types::op_lui, rv32i_types::op_auipc: d.imm = {w[31:12], 12'h000};
            rv32i_types::op_jal: d.imm = {sx[31:20], w[19:12], w[20], w[30:21], 1'b0};
            rv32i_types::op_branch: d.imm = {sx[31:12], w[7], w[30:25], w[11:8], 1'b0};
            rv32i_types::op_store: d.imm = {sx[31:12], w[31:25], w[11:7]};
            rv32i_types::op_imm, rv32i_types::op_load,
            rv32i_types::op_jalr: d.imm = {sx[31:12], w[31:20]};
            default: d.imm = 32'd0;
        endcase
        return d;
    endfunction

    // reset cycles, sampled values so the check is race free
    assert property (@(posedge clk) (rst && cycle_count > 0) |-> !imem_req)
        else report_mismatch("imem_req", $sampled(imem_req), 1'b0);
    assert property (@(posedge clk) (rst && cycle_count > 0) |-> !dec_valid)
        else report_mismatch("dec_valid", $sampled(dec_valid), 1'b0);

    initial begin
        logic [31:0] w;
        logic [31:0] pick;
        int          a;
        clk = 1'b0;
        rst = 1'b1;
        dec_ready = 1'b0;
        imem_rdata = 32'd0;
        seed = 32'h4a77;
        cycle_count = 0;
        accepted = 0;
        low_run = 0;
        high_run = 0;
        gap = 0;
        next_req_addr = rv32i_types::reset_pc;
        resp_pending = 1'b0;
        resp_addr = 32'd0;
        prev_stall = 1'b0;
        for (a = 0; a < 256; a++) begin
            w = $random(seed);
            pick = $random(seed);
            if (pick[2:0] == 3'd0) begin
                w[6:0] = pick[3] ? {pick[8:4], 2'b01} : 7'b1111011;  // illegal, ~1 in 8
            end else begin
                w[6:0] = legal_opcode(int'(pick[15:8]) % 9);
            end
            imem[a] = w;
        end
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        wait (accepted >= total_outputs);
        $display("Test passed");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            report_failure($sformatf("timeout after %0d cycles, only %0d outputs accepted",
                                     cycle_count, accepted));
        end
    end

    // memory answer and dec_ready, driven just after the edge
    always @(posedge clk) begin
        integer r;
        int     phase;
        #1;
        if (resp_pending) imem_rdata = imem[resp_addr[9:2]];
        phase = cycle_count % 100;
        r = $random(seed);
        if (phase < 40) dec_ready = 1'b1;
        else if (phase < 70) dec_ready = r[0];
        else if (phase < 95) dec_ready = 1'b0;   // long stall, queue fills up
        else dec_ready = 1'b1;
    end

    // all outputs are stable at the falling edge
    always @(negedge clk) begin
        rv32i_types::decoded_t want;
        logic [31:0]           head_pc;
        if (rst) begin
            check_value("imem_req", imem_req, 1'b0);
            check_value("dec_valid", dec_valid, 1'b0);
            resp_pending = 1'b0;
        end else begin
            if (prev_stall) begin
                check_value("dec_valid", dec_valid, 1'b1);
                check_value("dec_data", dec_data, prev_data);
            end
            prev_stall = dec_valid && !dec_ready;
            prev_data = dec_data;
            if (dec_valid && dec_ready) begin
                assert (pc_queue.size() > 0)
                    else report_failure("output accepted while no request was outstanding");
                head_pc = pc_queue.pop_front();
                want = ref_decode(head_pc, imem[head_pc[9:2]]);
                check_value("dec_data.pc", dec_data.pc, head_pc);
                check_value("dec_data.op", dec_data.op, want.op);
                check_value("dec_data.rd", dec_data.rd, want.rd);
                check_value("dec_data.rs1", dec_data.rs1, want.rs1);
                check_value("dec_data.rs2", dec_data.rs2, want.rs2);
                check_value("dec_data.funct3", dec_data.funct3, want.funct3);
                check_value("dec_data.funct7", dec_data.funct7, want.funct7);
                check_value("dec_data.imm", dec_data.imm, want.imm);
                check_value("dec_data.illegal", dec_data.illegal, want.illegal);
                accepted = accepted + 1;
                gap = 0;
            end else begin
                gap = gap + 1;
            end
            resp_pending = imem_req;
            if (imem_req) begin
                check_value("imem_addr", imem_addr, next_req_addr);
                pc_queue.push_back(next_req_addr);
                resp_addr = imem_addr;
                next_req_addr = next_req_addr + 32'd4;
            end
            assert (pc_queue.size() <= max_outstanding)
                else report_failure("too many requests outstanding, queue must have overflowed");
            if (dec_ready) begin
                high_run = high_run + 1;
                low_run = 0;
            end else begin
                low_run = low_run + 1;
                high_run = 0;
            end
            if (low_run >= 14) check_value("imem_req", imem_req, 1'b0);
            if (high_run >= 12) begin
                assert (gap < 2)
                    else report_failure("no output accepted in two cycles with dec_ready high");
            end
        end
    end

endmodule : frontend_tb

// ==== frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            imem_rdata,
    input  logic                   dec_ready,
    output logic                   imem_req,
    output logic [31:0]            imem_addr,
    output logic                   dec_valid,
    output rv32i_types::decoded_t  dec_data
);

    rv32i_types::fetch_entry_t enq_data;    // fetch to queue
    rv32i_types::fetch_entry_t head_data;   // queue head to decode
    logic                      enq_valid;
    logic                      dequeue;
    logic                      queue_full;
    logic                      queue_empty;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .imem_rdata (imem_rdata),
        .queue_full (queue_full),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .enq_valid  (enq_valid),
        .enq_data   (enq_data)
    );

    queue #(
        .DATA_WIDTH  ($bits(rv32i_types::fetch_entry_t)),
        .QUEUE_DEPTH (rv32i_types::fetch_queue_depth)
    ) u_queue (
        .clk        (clk),
        .rst        (rst),
        .wdata_in   (enq_data),
        .enqueue_in (enq_valid),
        .dequeue_in (dequeue),
        .rdata_out  (head_data),
        .full_out   (queue_full),
        .empty_out  (queue_empty)
    );

    decode_unit u_decode (
        .clk         (clk),
        .rst         (rst),
        .head_data   (head_data),
        .queue_empty (queue_empty),
        .dec_ready   (dec_ready),
        .dequeue     (dequeue),
        .dec_valid   (dec_valid),
        .dec_data    (dec_data)
    );

endmodule : frontend_top

// ==== decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  rv32i_types::fetch_entry_t  head_data,
    input  logic                       queue_empty,
    input  logic                       dec_ready,
    output logic                       dequeue,
    output logic                       dec_valid,
    output rv32i_types::decoded_t      dec_data
);

    rv32i_types::decoded_t dec_next;    // combinational decode of the head entry
    logic [31:0]           instr;

    logic valid_q;
    rv32i_types::decoded_t data_q;

    assign instr = head_data.instr;

    // pop when the output register is empty or leaving this cycle
    assign dequeue = !queue_empty && (!valid_q || dec_ready);

    assign dec_valid = valid_q;
    assign dec_data  = data_q;

    always_comb begin
        dec_next.pc     = head_data.pc;
        dec_next.rd     = instr[11:7];
        dec_next.rs1    = instr[19:15];
        dec_next.rs2    = instr[24:20];
        dec_next.funct3 = instr[14:12];
        dec_next.funct7 = instr[31:25];

        // every legal opcode has 11 in the low bits, so the default covers the rest
        case (instr[6:0])
            rv32i_types::op_lui:    dec_next.op = rv32i_types::op_lui;
            rv32i_types::op_auipc:  dec_next.op = rv32i_types::op_auipc;
            rv32i_types::op_jal:    dec_next.op = rv32i_types::op_jal;
            rv32i_types::op_jalr:   dec_next.op = rv32i_types::op_jalr;
            rv32i_types::op_branch: dec_next.op = rv32i_types::op_branch;
            rv32i_types::op_load:   dec_next.op = rv32i_types::op_load;
            rv32i_types::op_store:  dec_next.op = rv32i_types::op_store;
            rv32i_types::op_imm:    dec_next.op = rv32i_types::op_imm;
            rv32i_types::op_reg:    dec_next.op = rv32i_types::op_reg;
            default:                dec_next.op = rv32i_types::op_illegal;
        endcase

        dec_next.illegal = (dec_next.op == rv32i_types::op_illegal);

        case (dec_next.op)
            rv32i_types::op_imm,
            rv32i_types::op_load,
            rv32i_types::op_jalr: begin
                dec_next.imm = {{20{instr[31]}}, instr[31:20]};     // I type
            end
            rv32i_types::op_store: begin
                dec_next.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};    // S type
            end
            rv32i_types::op_branch: begin
                dec_next.imm = {{19{instr[31]}}, instr[31], instr[7],
                                instr[30:25], instr[11:8], 1'b0};   // B type
            end
            rv32i_types::op_lui,
            rv32i_types::op_auipc: begin
                dec_next.imm = {instr[31:12], 12'b0};   // U type
            end
            rv32i_types::op_jal: begin
                dec_next.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                instr[20], instr[30:21], 1'b0};     // J type
            end
            default: begin
                dec_next.imm = 32'd0;   // register ops and illegal words
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (dequeue) begin
            valid_q <= 1'b1;    // loaded in the same cycle as the pop
        end else if (dec_ready) begin
            valid_q <= 1'b0;
        end
    end

    // payload holds while stalled
    always_ff @(posedge clk) begin
        if (dequeue) begin
            data_q <= dec_next;
        end
    end

endmodule : decode_unit

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [31:0]                imem_rdata,
    input  logic                       queue_full,
    output logic                       imem_req,
    output logic [31:0]                imem_addr,
    output logic                       enq_valid,
    output rv32i_types::fetch_entry_t  enq_data
);

    logic [31:0] pc_q;          // address of the next request
    logic        running_q;     // set once reset has been released
    logic        pending_q;     // a response is due this cycle
    logic [31:0] pending_pc_q;  // pc of the word in flight

    // request only while the queue has room after this cycle;
    // full already counts the word being enqueued now
    assign imem_req = running_q && !queue_full;
    assign imem_addr = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            running_q <= 1'b0;
            pending_q <= 1'b0;
            pc_q      <= rv32i_types::reset_pc;
        end else begin
            running_q <= 1'b1;
            pending_q <= imem_req;      // fixed one-cycle memory latency
            if (imem_req) begin
                pc_q <= pc_q + 32'd4;   // sequential only, no redirect
            end
        end
    end

    // payload register, follows the request
    always_ff @(posedge clk) begin
        if (imem_req) begin
            pending_pc_q <= pc_q;
        end
    end

    // pair the returned word with its pc in the response cycle
    always_comb begin
        enq_valid      = pending_q;
        enq_data.pc    = pending_pc_q;
        enq_data.instr = imem_rdata;
    end

endmodule : fetch_unit

// ==== queue.sv ====
`timescale 1ns/1ps

module queue #(
    parameter int DATA_WIDTH = 64,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [DATA_WIDTH - 1:0] wdata_in,
    input  logic                    enqueue_in,
    input  logic                    dequeue_in,
    output logic [DATA_WIDTH - 1:0] rdata_out,
    output logic                    full_out,
    output logic                    empty_out
);

    // pointers carry one bit above the address to tell full from empty
    typedef logic [$clog2(QUEUE_DEPTH):0] ptr_t;

    ptr_t head_q;
    ptr_t tail_q;
    ptr_t head_d;   // combinational
    ptr_t tail_d;   // combinational

    logic [DATA_WIDTH - 1:0] mem [QUEUE_DEPTH];

    logic full_now;     // from the registered pointers
    logic empty_now;
    logic do_enq;       // accepted enqueue
    logic do_deq;       // accepted dequeue

    always_comb begin
        full_now = (tail_q[$clog2(QUEUE_DEPTH) - 1:0] == head_q[$clog2(QUEUE_DEPTH) - 1:0])
                && (tail_q[$clog2(QUEUE_DEPTH)] != head_q[$clog2(QUEUE_DEPTH)]);
        empty_now = (tail_q[$clog2(QUEUE_DEPTH) - 1:0] == head_q[$clog2(QUEUE_DEPTH) - 1:0])
                 && (tail_q[$clog2(QUEUE_DEPTH)] == head_q[$clog2(QUEUE_DEPTH)]);

        do_enq = enqueue_in && !full_now;
        do_deq = dequeue_in && !empty_now;

        tail_d = tail_q + ptr_t'(do_enq);  // wrap bit toggles on rollover
        head_d = head_q + ptr_t'(do_deq);
    end

    // look-ahead full: the producer sees the state after this cycle's traffic,
    // so a request issued now still has a slot when its word comes back
    assign full_out = (tail_d[$clog2(QUEUE_DEPTH) - 1:0] == head_d[$clog2(QUEUE_DEPTH) - 1:0])
                   && (tail_d[$clog2(QUEUE_DEPTH)] != head_d[$clog2(QUEUE_DEPTH)]);

    assign empty_out = empty_now;

    // first-word-fall-through: head entry is always on the output
    assign rdata_out = mem[head_q[$clog2(QUEUE_DEPTH) - 1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;   // both pointers reset together
            tail_q <= '0;
        end else begin
            head_q <= head_d;
            tail_q <= tail_d;
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[tail_q[$clog2(QUEUE_DEPTH) - 1:0]] <= wdata_in;
        end
    end

endmodule : queue

// ==== rv32i_types.sv ====
package rv32i_types;

    // front-end constants
    localparam logic [31:0] reset_pc = 32'h0000_0000;  // first fetch address
    localparam int fetch_queue_depth = 8;              // entries between fetch and decode

    // major opcodes, low seven bits of the instruction word
    typedef enum logic [6:0] {
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        op_branch  = 7'b1100011,
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_imm     = 7'b0010011,
        op_reg     = 7'b0110011,
        op_illegal = 7'b0000000  // stands for every other encoding
    } opcode_e;

    // one fetched word with the address it came from
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_entry_t;

    // decoded instruction record handed downstream
    typedef struct packed {
        logic [31:0] pc;
        opcode_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;      // sign-extended per format
        logic        illegal;
    } decoded_t;

endpackage : rv32i_types
